/* compile.f */
verilog/screen_pkg.sv
verilog/ctrl_pkg.sv
verilog/tick_timer.sv
verilog/sprite_control.sv
verilog/player_datapath.sv
verilog/bee_datapath.sv
verilog/plot_arbiter.sv
verilog/life_score.sv
verilog/beehive_top.sv
test/beehive_props.sv
test/tb_beehive.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_beehive -f compile.f -o tb_beehive_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_beehive_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* test/beehive_props.sv */
// property checker for the beehive plot stream, lives and score
`timescale 1ns/1ps

module beehive_props
	import screen_pkg::*;
	import ctrl_pkg::*;
(
	input logic     clk,
	input logic     resetn,
	input coord_x_t plot_x,
	input coord_y_t plot_y,
	input colour_t  plot_colour,
	input logic     plot_valid,
	input lives_t   lives,
	input score_t   score
);

	localparam colour_t PLAYER_COLOUR = 3'b111;

	int fail_bounds = 0;
	int fail_step_x = 0;
	int fail_step_y = 0;
	int fail_lives = 0;
	int fail_score = 0;

	// last plotted cell of each colour
	coord_x_t   last_x [8];
	coord_y_t   last_y [8];
	logic [7:0] seen;
	coord_x_t   prev_x;
	coord_y_t   prev_y;
	logic       player;
	logic       x_ok;
	logic       y_ok;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			seen   <= '0;
			last_x <= '{default: '0};
			last_y <= '{default: '0};
		end
		else if (plot_valid)
		begin
			seen[plot_colour]   <= 1'b1;
			last_x[plot_colour] <= plot_x;
			last_y[plot_colour] <= plot_y;
		end
	end

	assign prev_x = last_x[plot_colour];
	assign prev_y = last_y[plot_colour];
	assign player = (plot_colour == PLAYER_COLOUR);

	// one cell per move, the player may stay pinned at an edge
	assign x_ok = (plot_x == prev_x + 8'd1) || (prev_x == plot_x + 8'd1)
		|| (player && plot_x == prev_x && (prev_x == '0 || prev_x == X_MAX));
	assign y_ok = (plot_y == prev_y + 7'd1) || (prev_y == plot_y + 7'd1)
		|| (player && plot_y == prev_y && (prev_y == '0 || prev_y == Y_MAX));

	plot_in_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot_valid |-> (plot_x <= X_MAX) && (plot_y <= Y_MAX))
	else
	begin
		fail_bounds++;
		$error("ERR %0t plot_x %0d plot_y %0d outside the screen", $time, plot_x, plot_y);
	end

	step_x: assert property (@(posedge clk) disable iff (!resetn)
		plot_valid && seen[plot_colour] |-> x_ok)
	else
	begin
		fail_step_x++;
		$error("ERR %0t plot_x previous %0d now %0d", $time, prev_x, plot_x);
	end

	step_y: assert property (@(posedge clk) disable iff (!resetn)
		plot_valid && seen[plot_colour] |-> y_ok)
	else
	begin
		fail_step_y++;
		$error("ERR %0t plot_y previous %0d now %0d", $time, prev_y, plot_y);
	end

	// a life lost, or the refill that starts a new game
	lives_change: assert property (@(posedge clk) disable iff (!resetn)
		(lives != $past(lives)) |->
			($past(lives) != 2'd1 && lives == $past(lives) - 2'd1)
			|| ($past(lives) == 2'd1 && lives == MAX_LIVES && score == '0))
	else
	begin
		fail_lives++;
		$error("ERR %0t lives was %0d now %0d", $time, $past(lives), lives);
	end

	score_change: assert property (@(posedge clk) disable iff (!resetn)
		(score != $past(score)) |-> (score == $past(score) + 8'd1)
			|| (score == '0 && $past(lives) == 2'd1 && lives == MAX_LIVES))
	else
	begin
		fail_score++;
		$error("ERR %0t score was %0d now %0d", $time, $past(score), score);
	end

endmodule

bind beehive_top beehive_props props0 (
	.clk, .resetn, .plot_x, .plot_y, .plot_colour, .plot_valid, .lives, .score
);

/* test/tb_beehive.sv */
// testbench for the beehive game top level, joystick stimulus and final report
`timescale 1ns/1ps

module tb_beehive
	import screen_pkg::*;
	import ctrl_pkg::*;
();

	localparam int       MOVE_PERIOD  = 8;
	localparam int       SCORE_PERIOD = 20;
	localparam coord_x_t PLAYER_X     = 8'd70;
	localparam coord_y_t PLAYER_Y     = 7'd70;
	localparam coord_x_t BEE2_X       = 8'd40;
	localparam coord_y_t BEE2_Y       = 7'd40;
	localparam colour_t  WHITE        = 3'b111;
	localparam colour_t  BLUE         = 3'b001;
	localparam colour_t  GREEN        = 3'b010;
	localparam int       HOLD_CYCLES  = 40 * MOVE_PERIOD;
	localparam int       RANDOM_CYCLES = 200 * MOVE_PERIOD;
	localparam int       DRIVE_DELAY  = 2;

	logic        clk;
	logic        resetn;
	logic        joy_x;
	logic        joy_y;
	coord_x_t    plot_x;
	coord_y_t    plot_y;
	colour_t     plot_colour;
	logic        plot_valid;
	lives_t      lives;
	score_t      score;
	int          errors;
	int          cycle_count;
	int          total;
	logic [31:0] rnd;

	beehive_top #(
		.MOVE_PERIOD(MOVE_PERIOD), .SCORE_PERIOD(SCORE_PERIOD),
		.PLAYER_X(PLAYER_X), .PLAYER_Y(PLAYER_Y),
		.BEE1_X(PLAYER_X), .BEE1_Y(PLAYER_Y),
		.BEE2_X(BEE2_X), .BEE2_Y(BEE2_Y)
	) dut0 (
		.clk, .resetn, .joy_x, .joy_y,
		.plot_x, .plot_y, .plot_colour, .plot_valid, .lives, .score
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (resetn)
			cycle_count <= cycle_count + 1;
	end

	task automatic check_plot(input coord_x_t ex, input coord_y_t ey, input colour_t ec);
		assert (plot_valid) else
		begin
			errors++;
			$display("ERR %0t plot_valid got %0d expected 1", $time, plot_valid);
		end
		assert (plot_x == ex) else
		begin
			errors++;
			$display("ERR %0t plot_x got %0d expected %0d", $time, plot_x, ex);
		end
		assert (plot_y == ey) else
		begin
			errors++;
			$display("ERR %0t plot_y got %0d expected %0d", $time, plot_y, ey);
		end
		assert (plot_colour == ec) else
		begin
			errors++;
			$display("ERR %0t plot_colour got %0d expected %0d", $time, plot_colour, ec);
		end
	endtask

	// first plot after reset, then two more on the next cycles
	task automatic check_start_plots(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (!plot_valid && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (!plot_valid)
		begin
			errors++;
			$display("timeout, no plot appeared after reset");
		end
		else
		begin
			check_plot(PLAYER_X, PLAYER_Y, WHITE);
			@(negedge clk);
			check_plot(PLAYER_X, PLAYER_Y, BLUE);
			@(negedge clk);
			check_plot(BEE2_X, BEE2_Y, GREEN);
		end
	endtask

	task automatic wait_for_lives(input lives_t target, input int limit);
		int n;
		n = 0;
		while (lives != target && n < limit)
		begin
			@(negedge clk);
			n++;
		end
		if (lives != target)
		begin
			errors++;
			$display("timeout, lives never reached %0d", target);
		end
	endtask

	initial
	begin
		errors = 0;
		cycle_count = 0;
		void'($urandom(32'h08b54009));
		resetn = 1'b0;
		// same motion as bee 1, so every update is a collision
		joy_x = 1'b0;
		joy_y = 1'b1;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY resetn = 1'b1;
		check_start_plots(20);
		wait_for_lives(2'd1, 200);
		wait_for_lives(MAX_LIVES, 100);
		if (cycle_count < HOLD_CYCLES)
			repeat (HOLD_CYCLES - cycle_count) @(posedge clk);
		repeat (RANDOM_CYCLES)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			rnd = $urandom;
			joy_x = rnd[0];
			joy_y = rnd[1];
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		total = errors + dut0.props0.fail_bounds + dut0.props0.fail_step_x
			+ dut0.props0.fail_step_y + dut0.props0.fail_lives + dut0.props0.fail_score;
		$display("errors: start plots %0d, bounds %0d, step x %0d, step y %0d, lives %0d, score %0d",
			errors, dut0.props0.fail_bounds, dut0.props0.fail_step_x,
			dut0.props0.fail_step_y, dut0.props0.fail_lives, dut0.props0.fail_score);
		if (total == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verilog/bee_datapath.sv */
// bee datapath that moves a bee diagonally, bounces it off the screen edges and requests a plot
`timescale 1ns/1ps

module bee_datapath
	import screen_pkg::*;
#(
	parameter coord_x_t START_X = 8'd10,
	parameter coord_y_t START_Y = 7'd10,
	parameter colour_t  COLOUR  = 3'b001
) (
	input  logic     clk,
	input  logic     resetn,
	input  logic     load,
	input  logic     update,
	input  logic     grant,
	output coord_x_t pos_x,
	output coord_y_t pos_y,
	output colour_t  colour,
	output logic     req
);

	// direction flags, set means decreasing coordinate
	logic x_dec;
	logic y_dec;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			pos_x <= START_X;
			pos_y <= START_Y;
			x_dec <= 1'b0;
			y_dec <= 1'b1;
		end
		else if (load)
		begin
			pos_x <= START_X;
			pos_y <= START_Y;
			x_dec <= 1'b0;
			y_dec <= 1'b1;
		end
		else if (update)
		begin
			// x axis, reverse at either edge
			if (!x_dec && pos_x == X_MAX)
			begin
				x_dec <= 1'b1;
				pos_x <= pos_x - 8'd1;
			end
			else if (x_dec && pos_x == '0)
			begin
				x_dec <= 1'b0;
				pos_x <= pos_x + 8'd1;
			end
			else
				pos_x <= x_dec ? pos_x - 8'd1 : pos_x + 8'd1;
			// y axis
			if (!y_dec && pos_y == Y_MAX)
			begin
				y_dec <= 1'b1;
				pos_y <= pos_y - 7'd1;
			end
			else if (y_dec && pos_y == '0)
			begin
				y_dec <= 1'b0;
				pos_y <= pos_y + 7'd1;
			end
			else
				pos_y <= y_dec ? pos_y - 7'd1 : pos_y + 7'd1;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			req <= 1'b0;
		else if (load || update)
			req <= 1'b1;
		else if (grant)
			req <= 1'b0;
	end

	assign colour = COLOUR;

endmodule

/* verilog/beehive_top.sv */
// beehive game top level with timers, sprite control, sprite datapaths, plot merge and score
`timescale 1ns/1ps

module beehive_top
	import screen_pkg::*;
	import ctrl_pkg::*;
#(
	parameter int       MOVE_PERIOD  = 50000000,
	parameter int       SCORE_PERIOD = 50000000,
	parameter coord_x_t PLAYER_X     = 8'd70,
	parameter coord_y_t PLAYER_Y     = 7'd70,
	parameter coord_x_t BEE1_X       = 8'd10,
	parameter coord_y_t BEE1_Y       = 7'd10,
	parameter coord_x_t BEE2_X       = 8'd40,
	parameter coord_y_t BEE2_Y       = 7'd40
) (
	input  logic     clk,
	input  logic     resetn,
	input  logic     joy_x,
	input  logic     joy_y,
	output coord_x_t plot_x,
	output coord_y_t plot_y,
	output colour_t  plot_colour,
	output logic     plot_valid,
	output lives_t   lives,
	output score_t   score
);

	logic move_tick, score_tick, load, update;
	logic p_req, b1_req, b2_req;
	logic p_grant, b1_grant, b2_grant;
	coord_x_t p_x, b1_x, b2_x;
	coord_y_t p_y, b1_y, b2_y;
	colour_t  p_colour, b1_colour, b2_colour;

	tick_timer #(.PERIOD(MOVE_PERIOD)) move_timer (.clk, .resetn, .tick(move_tick));
	tick_timer #(.PERIOD(SCORE_PERIOD)) score_timer (.clk, .resetn, .tick(score_tick));

	sprite_control ctrl0 (.clk, .resetn, .move_tick, .load, .update);

	// player is white
	player_datapath #(.START_X(PLAYER_X), .START_Y(PLAYER_Y), .COLOUR(3'b111)) player0 (
		.clk, .resetn, .load, .update, .joy_x, .joy_y, .grant(p_grant),
		.pos_x(p_x), .pos_y(p_y), .colour(p_colour), .req(p_req)
	);

	// bee 1 blue, bee 2 green
	bee_datapath #(.START_X(BEE1_X), .START_Y(BEE1_Y), .COLOUR(3'b001)) bee1 (
		.clk, .resetn, .load, .update, .grant(b1_grant),
		.pos_x(b1_x), .pos_y(b1_y), .colour(b1_colour), .req(b1_req)
	);

	bee_datapath #(.START_X(BEE2_X), .START_Y(BEE2_Y), .COLOUR(3'b010)) bee2 (
		.clk, .resetn, .load, .update, .grant(b2_grant),
		.pos_x(b2_x), .pos_y(b2_y), .colour(b2_colour), .req(b2_req)
	);

	plot_arbiter arb0 (
		.clk, .resetn,
		.p_req, .p_x, .p_y, .p_colour,
		.b1_req, .b1_x, .b1_y, .b1_colour,
		.b2_req, .b2_x, .b2_y, .b2_colour,
		.p_grant, .b1_grant, .b2_grant,
		.plot_x, .plot_y, .plot_colour, .plot_valid
	);

	life_score score0 (
		.clk, .resetn, .update, .score_tick,
		.p_x, .p_y, .b1_x, .b1_y, .b2_x, .b2_y,
		.lives, .score
	);

endmodule

/* verilog/ctrl_pkg.sv */
// control package with the sprite FSM states and the score and lives types
package ctrl_pkg;

	// sprite sequencing states
	typedef enum logic [1:0] {
		S_LOAD,
		S_WAIT,
		S_UPDATE
	} sprite_state_t;

	typedef logic [1:0] lives_t;
	typedef logic [7:0] score_t;

	localparam lives_t MAX_LIVES = 2'd3;

endpackage

/* verilog/life_score.sv */
// lives and score unit that detects collisions, counts lives and counts the score
`timescale 1ns/1ps

module life_score
	import screen_pkg::*;
	import ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	input  logic     update,
	input  logic     score_tick,
	input  coord_x_t p_x,
	input  coord_y_t p_y,
	input  coord_x_t b1_x,
	input  coord_y_t b1_y,
	input  coord_x_t b2_x,
	input  coord_y_t b2_y,
	output lives_t   lives,
	output score_t   score
);

	// positions settle one cycle after update
	logic update_d;
	logic hit;

	assign hit = ((p_x == b1_x) && (p_y == b1_y)) || ((p_x == b2_x) && (p_y == b2_y));

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			update_d <= 1'b0;
			lives    <= MAX_LIVES;
			score    <= '0;
		end
		else
		begin
			update_d <= update;
			if (update_d && hit && lives == 2'd1)
			begin
				// last life gone, start a new game
				lives <= MAX_LIVES;
				score <= '0;
			end
			else
			begin
				if (update_d && hit)
					lives <= lives - 2'd1;
				if (score_tick)
					score <= score + 8'd1;
			end
		end
	end

endmodule

/* verilog/player_datapath.sv */
// player datapath that moves the player sprite from the joystick and requests a plot
`timescale 1ns/1ps

module player_datapath
	import screen_pkg::*;
#(
	parameter coord_x_t START_X = 8'd70,
	parameter coord_y_t START_Y = 7'd70,
	parameter colour_t  COLOUR  = 3'b111
) (
	input  logic     clk,
	input  logic     resetn,
	input  logic     load,
	input  logic     update,
	input  logic     joy_x,
	input  logic     joy_y,
	input  logic     grant,
	output coord_x_t pos_x,
	output coord_y_t pos_y,
	output colour_t  colour,
	output logic     req
);

	// one cell per update on each axis, held at the screen edge
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			pos_x <= START_X;
			pos_y <= START_Y;
		end
		else if (load)
		begin
			pos_x <= START_X;
			pos_y <= START_Y;
		end
		else if (update)
		begin
			// joy_x high is left
			if (joy_x && pos_x != '0)
				pos_x <= pos_x - 8'd1;
			else if (!joy_x && pos_x != X_MAX)
				pos_x <= pos_x + 8'd1;
			// joy_y high is up, toward y = 0
			if (joy_y && pos_y != '0)
				pos_y <= pos_y - 7'd1;
			else if (!joy_y && pos_y != Y_MAX)
				pos_y <= pos_y + 7'd1;
		end
	end

	// request held until the arbiter grants it
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			req <= 1'b0;
		else if (load || update)
			req <= 1'b1;
		else if (grant)
			req <= 1'b0;
	end

	assign colour = COLOUR;

endmodule

/* verilog/plot_arbiter.sv */
// plot arbiter that merges the sprite plot requests into one registered plot stream
`timescale 1ns/1ps

module plot_arbiter
	import screen_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	input  logic     p_req,
	input  coord_x_t p_x,
	input  coord_y_t p_y,
	input  colour_t  p_colour,
	input  logic     b1_req,
	input  coord_x_t b1_x,
	input  coord_y_t b1_y,
	input  colour_t  b1_colour,
	input  logic     b2_req,
	input  coord_x_t b2_x,
	input  coord_y_t b2_y,
	input  colour_t  b2_colour,
	output logic     p_grant,
	output logic     b1_grant,
	output logic     b2_grant,
	output coord_x_t plot_x,
	output coord_y_t plot_y,
	output colour_t  plot_colour,
	output logic     plot_valid
);

	// player first, then bee 1, then bee 2
	assign p_grant  = p_req;
	assign b1_grant = b1_req && !p_req;
	assign b2_grant = b2_req && !p_req && !b1_req;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			plot_x      <= '0;
			plot_y      <= '0;
			plot_colour <= '0;
			plot_valid  <= 1'b0;
		end
		else
		begin
			plot_valid <= p_grant || b1_grant || b2_grant;
			if (p_grant)
			begin
				plot_x      <= p_x;
				plot_y      <= p_y;
				plot_colour <= p_colour;
			end
			else if (b1_grant)
			begin
				plot_x      <= b1_x;
				plot_y      <= b1_y;
				plot_colour <= b1_colour;
			end
			else if (b2_grant)
			begin
				plot_x      <= b2_x;
				plot_y      <= b2_y;
				plot_colour <= b2_colour;
			end
		end
	end

endmodule

/* verilog/screen_pkg.sv */
// screen package with screen geometry, cell coordinate types and colour types
package screen_pkg;

	// screen size in cells
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	// cell coordinates
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;

	// one bit each for red, green, blue
	typedef logic [2:0] colour_t;

	// last cell on each axis
	localparam coord_x_t X_MAX = coord_x_t'(SCREEN_W - 1);
	localparam coord_y_t Y_MAX = coord_y_t'(SCREEN_H - 1);

endpackage

/* verilog/sprite_control.sv */
// sprite control FSM that sequences the load and update steps of the sprite datapaths
`timescale 1ns/1ps

module sprite_control
	import ctrl_pkg::*;
(
	input  logic clk,
	input  logic resetn,
	input  logic move_tick,
	output logic load,
	output logic update
);

	sprite_state_t state;
	sprite_state_t next_state;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			state <= S_LOAD;
		else
			state <= next_state;
	end

	// load once, then wait for a move tick between updates
	always_comb
	begin
		case (state)
			S_LOAD:   next_state = S_WAIT;
			S_WAIT:   next_state = move_tick ? S_UPDATE : S_WAIT;
			S_UPDATE: next_state = S_WAIT;
			default:  next_state = S_LOAD;
		endcase
	end

	assign load   = (state == S_LOAD);
	assign update = (state == S_UPDATE);

endmodule

/* verilog/tick_timer.sv */
// tick timer that raises a one-cycle tick once every PERIOD clock cycles
`timescale 1ns/1ps

module tick_timer #(
	parameter int PERIOD = 50000000
) (
	input  logic clk,
	input  logic resetn,
	output logic tick
);

	localparam int W = (PERIOD > 1) ? $clog2(PERIOD) : 1;
	localparam logic [W-1:0] RELOAD = W'(PERIOD - 1);

	logic [W-1:0] count;

	// down-counter, reloads after reaching zero
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			count <= RELOAD;
		else if (count == '0)
			count <= RELOAD;
		else
			count <= count - 1'b1;
	end

	assign tick = (count == '0);

endmodule
